/* cnn_pkg.sv */
package cnn_pkg;

   // layer geometry
   localparam int num_channels = 3;
   localparam int kernel_taps = 9;

   // 27 weights, channel-major then tap, then one bias word
   localparam int coefs_per_filter = num_channels * kernel_taps + 1;

   // lowest sum bit kept in the 8-bit output feature
   localparam int out_lsb = 4;

   // channel index inside a pixel and inside a coefficient set
   localparam int ch_r = 0;
   localparam int ch_g = 1;
   localparam int ch_b = 2;

   // one unsigned colour sample, also one output feature
   typedef logic [7:0] chan_t;

   // weights and biases share one format
   typedef logic signed [15:0] weight_t;

   // 9-bit signed sample times 16-bit weight is 25 bits, nine of them add 4
   typedef logic signed [28:0] dot_t;

   // three dots plus bias, room to spare
   typedef logic signed [31:0] acc_t;

   // r in the top byte, same order as the incoming 24-bit word
   typedef struct packed {
      chan_t r;
      chan_t g;
      chan_t b;
   } pixel_t;

   // tap0 oldest, tap0..2 top row, tap6..8 bottom row
   typedef struct packed {
      pixel_t tap8;
      pixel_t tap7;
      pixel_t tap6;
      pixel_t tap5;
      pixel_t tap4;
      pixel_t tap3;
      pixel_t tap2;
      pixel_t tap1;
      pixel_t tap0;
   } window_t;

   // full coefficient set of one filter, 448 bits
   typedef struct packed {
      weight_t [num_channels-1:0][kernel_taps-1:0] w;
      weight_t bias;
   } filter_coef_t;

endpackage

/* line_window.sv */
module line_window
   import cnn_pkg::*;
#(
   parameter int img_width = 8
) (
   input  logic    clk,
   input  logic    rst,
   input  logic    pix_valid,
   input  pixel_t  pix,
   output window_t window,
   output logic    window_valid
);

   // two full rows plus three pixels of the third
   localparam int depth = 2 * img_width + 3;
   localparam int cnt_w = $clog2(depth + 1);

   typedef logic [cnt_w-1:0] fill_t;

   // index 0 is the oldest pixel, depth-1 the newest
   pixel_t buf_q [depth];
   fill_t  fill_cnt;
   logic   full_q;

   // shift only on accepted pixels
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         for (int i = 0; i < depth; i++) begin
            buf_q[i] <= '0;
         end
      end else if (pix_valid) begin
         for (int i = 0; i < depth - 1; i++) begin
            buf_q[i] <= buf_q[i+1];
         end
         buf_q[depth-1] <= pix;
      end
   end

   // saturating fill count
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         fill_cnt <= '0;
      end else if (pix_valid && fill_cnt != fill_t'(depth)) begin
         fill_cnt <= fill_cnt + 1'b1;
      end
   end

   // set by a pixel that reaches full or arrives after it
   // low on idle cycles, so one window per accepted pixel
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         full_q <= 1'b0;
      end else begin
         full_q <= pix_valid && (fill_cnt >= fill_t'(depth - 1));
      end
   end

   assign window_valid = full_q;

   // top row
   assign window.tap0 = buf_q[0];
   assign window.tap1 = buf_q[1];
   assign window.tap2 = buf_q[2];
   // middle row
   assign window.tap3 = buf_q[img_width];
   assign window.tap4 = buf_q[img_width+1];
   assign window.tap5 = buf_q[img_width+2];
   // bottom row, newest pixel last
   assign window.tap6 = buf_q[2*img_width];
   assign window.tap7 = buf_q[2*img_width+1];
   assign window.tap8 = buf_q[2*img_width+2];

   // a window only leaves once the buffer has been filled
   a_valid_needs_full : assert property (
      @(posedge clk) disable iff (rst)
      window_valid |-> fill_cnt == fill_t'(depth)
   );

endmodule

/* channel_mac.sv */
module channel_mac
   import cnn_pkg::*;
(
   input  chan_t   [kernel_taps-1:0] samples,
   input  weight_t [kernel_taps-1:0] weights,
   output dot_t                      dot
);

   // 9-bit signed sample times 16-bit weight
   logic signed [24:0] prod [kernel_taps];
   // pairwise sums, one bit wider per level
   logic signed [25:0] lvl1 [4];
   logic signed [26:0] lvl2 [2];
   logic signed [27:0] lvl3;

   always_comb begin
      for (int i = 0; i < kernel_taps; i++) begin
         // samples are unsigned, pad a zero sign bit
         prod[i] = $signed({1'b0, samples[i]}) * $signed(weights[i]);
      end
   end

   always_comb begin
      for (int k = 0; k < 4; k++) begin
         lvl1[k] = prod[2*k] + prod[2*k+1];
      end
      for (int k = 0; k < 2; k++) begin
         lvl2[k] = lvl1[2*k] + lvl1[2*k+1];
      end
      lvl3 = lvl2[0] + lvl2[1];
   end

   // odd ninth tap joins at the root
   assign dot = lvl3 + prod[kernel_taps-1];

endmodule

/* filter_engine.sv */
module filter_engine
   import cnn_pkg::*;
(
   input  logic         clk,
   input  logic         rst,
   input  window_t      window,
   input  logic         window_valid,
   input  filter_coef_t coefs,
   output logic         out_valid,
   output chan_t        out_pix
);

   pixel_t taps [kernel_taps];
   // per-channel view of the window
   chan_t [num_channels-1:0][kernel_taps-1:0] samp;
   dot_t  dots [num_channels];
   acc_t  acc;
   chan_t relu_pix;

   // oldest first, matching the weight order
   assign taps[0] = window.tap0;
   assign taps[1] = window.tap1;
   assign taps[2] = window.tap2;
   assign taps[3] = window.tap3;
   assign taps[4] = window.tap4;
   assign taps[5] = window.tap5;
   assign taps[6] = window.tap6;
   assign taps[7] = window.tap7;
   assign taps[8] = window.tap8;

   // split pixels into colour planes
   always_comb begin
      for (int t = 0; t < kernel_taps; t++) begin
         samp[ch_r][t] = taps[t].r;
         samp[ch_g][t] = taps[t].g;
         samp[ch_b][t] = taps[t].b;
      end
   end

   // one dot product per colour
   for (genvar ch = 0; ch < num_channels; ch++) begin : g_mac
      channel_mac i_channel_mac (
         .samples (samp[ch]),
         .weights (coefs.w[ch]),
         .dot     (dots[ch])
      );
   end

   // cross-channel sum plus bias, cannot overflow 32 bits
   assign acc = acc_t'(dots[ch_r]) + acc_t'(dots[ch_g]) + acc_t'(dots[ch_b])
              + acc_t'(coefs.bias);

   // relu then keep bits 11..4, upper bits simply drop
   assign relu_pix = (acc > 0) ? acc[out_lsb+7:out_lsb] : '0;

   // one-cycle pulse per window
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         out_valid <= 1'b0;
      end else begin
         out_valid <= window_valid;
      end
   end

   // result only loads with a window
   always_ff @(posedge clk) begin
      if (window_valid) begin
         out_pix <= relu_pix;
      end
   end

   // window and coefficients must both be clean by the time they reach here
   a_out_known : assert property (
      @(posedge clk) disable iff (rst)
      out_valid |-> !$isunknown(out_pix)
   );

endmodule

/* coef_bank.sv */
module coef_bank
   import cnn_pkg::*;
#(
   parameter int num_filters = 4
) (
   input  logic                                          clk,
   input  logic                                          rst,
   input  logic                                          coef_wr,
   input  logic [$clog2(num_filters*coefs_per_filter)-1:0] coef_addr,
   input  weight_t                                       coef_data,
   output filter_coef_t [num_filters-1:0]                coefs
);

   localparam int num_words = num_filters * coefs_per_filter;
   // bias sits after the 27 weights
   localparam int bias_word = num_channels * kernel_taps;

   // flat word store, address = filter * 28 + word
   weight_t mem [num_words];

   // cleared bank means all filters output zero
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         for (int i = 0; i < num_words; i++) begin
            mem[i] <= '0;
         end
      end else if (coef_wr) begin
         mem[coef_addr] <= coef_data;
      end
   end

   // structured view per filter
   always_comb begin
      for (int f = 0; f < num_filters; f++) begin
         for (int ch = 0; ch < num_channels; ch++) begin
            for (int t = 0; t < kernel_taps; t++) begin
               // channel-major, then tap
               coefs[f].w[ch][t] = mem[f*coefs_per_filter + ch*kernel_taps + t];
            end
         end
         coefs[f].bias = mem[f*coefs_per_filter + bias_word];
      end
   end

   // out-of-range writes would be silently lost
   a_addr_range : assert property (
      @(posedge clk) disable iff (rst)
      coef_wr |-> int'(coef_addr) < num_words
   );

endmodule

/* conv_layer.sv */
module conv_layer
   import cnn_pkg::*;
#(
   parameter int img_width   = 8,
   parameter int num_filters = 4
) (
   input  logic                                          clk,
   input  logic                                          rst,
   input  logic                                          pix_valid,
   input  pixel_t                                        pix,
   input  logic                                          coef_wr,
   input  logic [$clog2(num_filters*coefs_per_filter)-1:0] coef_addr,
   input  weight_t                                       coef_data,
   output logic                                          out_valid,
   output chan_t [num_filters-1:0]                       out_pix
);

   window_t                        window;
   logic                           window_valid;
   filter_coef_t [num_filters-1:0] coefs;
   // one pulse per engine, all in lockstep
   logic [num_filters-1:0]         valid_bits;

   // line buffer and 3x3 window
   line_window #(
      .img_width (img_width)
   ) i_line_window (
      .clk          (clk),
      .rst          (rst),
      .pix_valid    (pix_valid),
      .pix          (pix),
      .window       (window),
      .window_valid (window_valid)
   );

   // weights and biases for every filter
   coef_bank #(
      .num_filters (num_filters)
   ) i_coef_bank (
      .clk       (clk),
      .rst       (rst),
      .coef_wr   (coef_wr),
      .coef_addr (coef_addr),
      .coef_data (coef_data),
      .coefs     (coefs)
   );

   // one engine per output channel, filter 0 in the low byte
   for (genvar f = 0; f < num_filters; f++) begin : g_filter
      filter_engine i_filter_engine (
         .clk          (clk),
         .rst          (rst),
         .window       (window),
         .window_valid (window_valid),
         .coefs        (coefs[f]),
         .out_valid    (valid_bits[f]),
         .out_pix      (out_pix[f])
      );
   end

   // same window_valid feeds all engines
   assign out_valid = valid_bits[0];

endmodule

/* tb_conv_layer.sv */
module tb_conv_layer
   import cnn_pkg::*;
();

   // must match the DUT defaults
   localparam int img_width   = 8;
   localparam int num_filters = 4;
   localparam int depth       = 2 * img_width + 3;
   localparam int num_words   = num_filters * coefs_per_filter;
   localparam int addr_w      = $clog2(num_words);
   localparam int out_w       = 8 * num_filters;

   // six coefficient loads plus the streaming, resets and drains of all tests
   localparam int stim_cycles = 6 * (num_words + 2) + 200 + 400 + 40 + 3 * 40 + 8 * depth;
   localparam int timeout     = 4 * stim_cycles * 10 + 2000;

   logic                    clk;
   logic                    rst;
   logic                    pix_valid;
   pixel_t                  pix;
   logic                    coef_wr;
   logic [addr_w-1:0]       coef_addr;
   weight_t                 coef_data;
   logic                    out_valid;
   chan_t [num_filters-1:0] out_pix;

   integer seed;

   // model state
   weight_t        cw [num_filters][coefs_per_filter];
   pixel_t         hist [$];
   logic [out_w-1:0] exp_q [$];
   logic [out_w-1:0] last_out;

   // bookkeeping
   string test_name;
   int    edges;
   int    accepted;
   int    fill_edge;
   int    first_out_edge;
   int    out_cnt;
   int    test_errs;
   int    errors;
   int    checks;
   int    passed;
   int    failed;

   conv_layer i_conv_layer (
      .clk       (clk),
      .rst       (rst),
      .pix_valid (pix_valid),
      .pix       (pix),
      .coef_wr   (coef_wr),
      .coef_addr (coef_addr),
      .coef_data (coef_data),
      .out_valid (out_valid),
      .out_pix   (out_pix)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // holds N in the low phase after rising edge N
   always @(posedge clk) begin
      edges <= edges + 1;
   end

   task automatic compare(input string name, input logic [63:0] expected,
                          input logic [63:0] actual);
      checks++;
      if (expected !== actual) begin
         $display("MISMATCH %s expected %h actual %h", name, expected, actual);
         test_errs++;
      end
   endtask

   // one expected word for the newest window in the history
   function automatic logic [out_w-1:0] model_result();
      int     off;
      longint s;
      chan_t  smp;
      pixel_t p;
      logic [out_w-1:0] r;
      r = '0;
      for (int f = 0; f < num_filters; f++) begin
         s = longint'(cw[f][coefs_per_filter-1]);
         for (int ch = 0; ch < num_channels; ch++) begin
            for (int t = 0; t < kernel_taps; t++) begin
               // tap row times width plus tap column
               off = (t / 3) * img_width + (t % 3);
               p = hist[off];
               smp = (ch == 0) ? p.r : (ch == 1) ? p.g : p.b;
               s += longint'(smp) * longint'(cw[f][ch*kernel_taps+t]);
            end
         end
         // relu then bits 11..4
         if (s > 0) begin
            r[8*f +: 8] = s[out_lsb +: 8];
         end
      end
      return r;
   endfunction

   // sample outputs in the low phase
   always @(negedge clk) begin
      if (out_valid === 1'b1) begin
         out_cnt++;
         last_out = out_pix;
         if (first_out_edge < 0) begin
            first_out_edge = edges;
         end
         if (exp_q.size() == 0) begin
            $display("test %s: out_valid went high with no result pending", test_name);
            test_errs++;
         end else begin
            compare(test_name, exp_q.pop_front(), out_pix);
         end
      end
   end

   // model follows the DUT into reset
   task automatic apply_reset();
      @(posedge clk);
      rst <= 1'b1;
      pix_valid <= 1'b0;
      coef_wr <= 1'b0;
      hist.delete();
      exp_q.delete();
      accepted = 0;
      fill_edge = -1;
      first_out_edge = -1;
      for (int f = 0; f < num_filters; f++) begin
         for (int w = 0; w < coefs_per_filter; w++) begin
            cw[f][w] = '0;
         end
      end
      repeat (2) @(posedge clk);
      rst <= 1'b0;
   endtask

   // one word per cycle from the model copy
   task automatic load_coefs();
      for (int f = 0; f < num_filters; f++) begin
         for (int w = 0; w < coefs_per_filter; w++) begin
            @(posedge clk);
            coef_wr <= 1'b1;
            coef_addr <= addr_w'(f * coefs_per_filter + w);
            coef_data <= cw[f][w];
         end
      end
      @(posedge clk);
      coef_wr <= 1'b0;
   endtask

   task automatic random_coefs();
      for (int f = 0; f < num_filters; f++) begin
         for (int w = 0; w < coefs_per_filter; w++) begin
            cw[f][w] = $random(seed);
         end
      end
   endtask

   // idle cycles still carry a random pixel on the bus
   task automatic drive_pixel(input logic valid);
      logic [31:0] rnd;
      pixel_t      p;
      rnd = $random(seed);
      p = rnd[23:0];
      @(posedge clk);
      pix_valid <= valid;
      pix <= p;
      if (valid) begin
         hist.push_back(p);
         if (hist.size() > depth) begin
            void'(hist.pop_front());
         end
         accepted++;
         // taken by the DUT at the next edge
         if (accepted == depth) begin
            fill_edge = edges + 2;
         end
         if (accepted >= depth) begin
            exp_q.push_back(model_result());
         end
      end
   endtask

   task automatic stream(input int n);
      for (int i = 0; i < n; i++) begin
         drive_pixel(1'b1);
      end
   endtask

   // stop input and wait for every pending result
   task automatic drain();
      @(posedge clk);
      pix_valid <= 1'b0;
      while (exp_q.size() != 0) begin
         @(posedge clk);
      end
      // a few more cycles to catch stray pulses
      repeat (3) @(posedge clk);
   endtask

   task automatic start_test(input string name);
      test_name = name;
      test_errs = 0;
      out_cnt = 0;
   endtask

   task automatic check_count();
      compare({test_name, " output count"}, accepted - (depth - 1), out_cnt);
   endtask

   task automatic end_test();
      errors += test_errs;
      if (test_errs == 0) begin
         passed++;
         $display("test %s: pass, %0d outputs", test_name, out_cnt);
      end else begin
         failed++;
         $display("test %s: FAIL, %0d errors", test_name, test_errs);
      end
   endtask

   initial begin
      #(timeout);
      $display("timeout: run did not finish within %0d time units", timeout);
      $display("Something failed");
      $finish;
   end

   initial begin
      int half;
      seed = 9;
      rst = 1'b1;
      pix_valid = 1'b0;
      pix = '0;
      coef_wr = 1'b0;
      coef_addr = '0;
      coef_data = '0;
      edges = 0;
      errors = 0;
      checks = 0;
      passed = 0;
      failed = 0;
      half = num_filters / 2;

      // first window and its latency
      start_test("fill");
      apply_reset();
      random_coefs();
      load_coefs();
      stream(depth + 4);
      drain();
      // first pulse is seen by the edge after it rises
      compare("fill first out_valid edge", fill_edge + 2, first_out_edge + 1);
      check_count();
      end_test();

      start_test("streaming");
      apply_reset();
      random_coefs();
      load_coefs();
      stream(200);
      drain();
      check_count();
      end_test();

      // valid about half the time
      start_test("gapped");
      apply_reset();
      random_coefs();
      load_coefs();
      while (accepted < 200) begin
         drive_pixel(($random(seed) & 1) == 1);
      end
      drain();
      check_count();
      end_test();

      start_test("relu_slice");
      apply_reset();
      for (int f = 0; f < num_filters; f++) begin
         for (int w = 0; w < coefs_per_filter - 1; w++) begin
            // small weights keep the negative-bias sums below zero
            cw[f][w] = (f < half) ? weight_t'($random(seed) % 4) : '0;
         end
         if (f < half) begin
            cw[f][coefs_per_filter-1] = 16'sh8000;
         end else begin
            cw[f][coefs_per_filter-1] = ($random(seed) & 16'h7fff) | 16'h0010;
         end
      end
      load_coefs();
      stream(40);
      drain();
      for (int f = 0; f < num_filters; f++) begin
         if (f < half) begin
            compare("relu_slice negative bias", 8'h00, last_out[8*f +: 8]);
         end else begin
            compare("relu_slice bias bits", cw[f][coefs_per_filter-1][11:4],
                    last_out[8*f +: 8]);
         end
      end
      check_count();
      end_test();

      // reset lands while results are in flight
      start_test("mid_reset");
      apply_reset();
      random_coefs();
      load_coefs();
      stream(30);
      apply_reset();
      out_cnt = 0;
      // cleared bank gives zero outputs after refill
      stream(depth + 10);
      drain();
      compare("mid_reset refill edge", fill_edge + 2, first_out_edge + 1);
      random_coefs();
      load_coefs();
      stream(30);
      drain();
      check_count();
      end_test();

      $display("tests run %0d, passed %0d, failed %0d, checks %0d, errors %0d",
               passed + failed, passed, failed, checks, errors);
      if (errors == 0) begin
         $display("Everything OK");
      end else begin
         $display("Something failed");
      end
      $finish;
   end

endmodule

/* flist.f */
cnn_pkg.sv
line_window.sv
channel_mac.sv
filter_engine.sv
coef_bank.sv
conv_layer.sv
tb_conv_layer.sv

/* Makefile */
# Verilator simulation of the convolution layer

VERILATOR ?= verilator
TOP       ?= tb_conv_layer
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Everything OK

.PHONY: sim clean

# build, run, and fail unless the pass line is printed
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
